// ==== design/ipsum_cfg_pkg.sv ====
package ipsum_cfg_pkg;

    // Data word and address widths of the ipsum path
    localparam int unsigned WORD_W = 32;
    localparam int unsigned ADDR_W = 16;
    localparam int unsigned POP_W  = 16;

    // Default sizes, overridden through ipsum_top parameters
    localparam int unsigned FIFO_DEPTH_DEF = 8;
    localparam int unsigned GLB_DEPTH_DEF  = 256;

    // One partial sum as stored in the GLB and the FIFO
    typedef logic [WORD_W-1:0] ipsum_word_t;

    // GLB word address, wraps inside glb_bank
    typedef logic [ADDR_W-1:0] glb_addr_t;

    // Number of words popped by one task
    typedef logic [POP_W-1:0] pop_num_t;

endpackage

// ==== design/ipsum_ctrl_pkg.sv ====
package ipsum_ctrl_pkg;

    // Controller phases
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        POP  = 2'd1,
        PUSH = 2'd2
    } ctrl_state_t;

    // FIFO occupancy flags seen by the controller
    typedef struct packed {
        logic full;
        logic empty;
    } fifo_status_t;

    // Read request toward the GLB arbiter
    typedef struct packed {
        logic                    req;
        ipsum_cfg_pkg::glb_addr_t addr;
    } glb_rd_req_t;

    // Arbiter decision for the single GLB read port
    typedef struct packed {
        logic                    permit_ipsum;
        ipsum_cfg_pkg::glb_addr_t addr;
    } glb_rd_grant_t;

endpackage

// ==== design/ipsum_fifo_ctrl.sv ====
`timescale 1ns/1ps

module ipsum_fifo_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,

    // Task interface
    input  logic                          need_pop_i,
    input  ipsum_cfg_pkg::pop_num_t       pop_num_i,
    input  logic                          fifo_reset_i,
    input  ipsum_cfg_pkg::glb_addr_t      base_addr_i,

    // FIFO flags and arbiter permit
    input  ipsum_ctrl_pkg::fifo_status_t  fifo_status_i,
    input  logic                          permit_push_i,

    // GLB read request, FIFO strobes and task status
    output ipsum_ctrl_pkg::glb_rd_req_t   rd_req_o,
    output logic                          push_o,
    output logic                          pop_o,
    output logic                          done_o
);

    import ipsum_cfg_pkg::*;
    import ipsum_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    pop_num_t  pop_num_q;
    pop_num_t  pop_cnt_q;
    glb_addr_t rd_ptr_q;
    logic      last_pop;

    // Last word of the task leaves the FIFO this cycle
    assign last_pop = pop_o && (pop_cnt_q == pop_num_q - pop_num_t'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (need_pop_i && !fifo_status_i.empty) begin
                    state_d = POP;
                end else if (need_pop_i) begin
                    state_d = PUSH;
                end
            end
            POP: begin
                // Ran dry mid task, go refill
                if (fifo_status_i.empty) begin
                    state_d = PUSH;
                end else if (last_pop) begin
                    state_d = IDLE;
                end
            end
            PUSH: begin
                if (fifo_status_i.full) begin
                    state_d = POP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Pop count of the task, latched at start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_num_q <= '0;
        end else if (state_q == IDLE && need_pop_i) begin
            pop_num_q <= pop_num_i;
        end
    end

    // Words popped so far in this task
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_cnt_q <= '0;
        end else if (state_q == IDLE) begin
            pop_cnt_q <= '0;
        end else if (pop_o) begin
            pop_cnt_q <= pop_cnt_q + pop_num_t'(1);
        end
    end

    // GLB offset of the next word to fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
        end else if (fifo_reset_i) begin
            rd_ptr_q <= '0;
        end else if (push_o) begin
            rd_ptr_q <= rd_ptr_q + glb_addr_t'(1);
        end
    end

    // Request only while there is room in the FIFO
    assign rd_req_o.req  = (state_q == PUSH) && !fifo_status_i.full;
    assign rd_req_o.addr = base_addr_i + rd_ptr_q;

    assign push_o = rd_req_o.req && permit_push_i;
    assign pop_o  = (state_q == POP) && !fifo_status_i.empty;
    assign done_o = (state_q == IDLE);

endmodule

// ==== design/ipsum_fifo.sv ====
`timescale 1ns/1ps

module ipsum_fifo #(
    parameter int unsigned FIFO_DEPTH = ipsum_cfg_pkg::FIFO_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clear_i,
    input  logic                          push_i,
    input  ipsum_cfg_pkg::ipsum_word_t    push_data_i,
    input  logic                          pop_i,
    output ipsum_cfg_pkg::ipsum_word_t    head_o,
    output ipsum_ctrl_pkg::fifo_status_t  status_o
);

    import ipsum_cfg_pkg::*;

    localparam int unsigned PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);
    localparam logic [PW-1:0] LAST_PTR = PW'(FIFO_DEPTH - 1);
    localparam logic [CW-1:0] DEPTH_C  = CW'(FIFO_DEPTH);

    ipsum_word_t   mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          do_push;
    logic          do_pop;

    // Overflow and underflow are blocked here as well
    assign do_push = push_i && !status_o.full;
    assign do_pop  = pop_i && !status_o.empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + PW'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + PW'(1);
            end
            unique case ({do_push, do_pop})
                2'b10:   count_q <= count_q + CW'(1);
                2'b01:   count_q <= count_q - CW'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // Head word is visible without popping
    assign head_o         = mem[rd_ptr_q];
    assign status_o.full  = (count_q == DEPTH_C);
    assign status_o.empty = (count_q == '0);

endmodule

// ==== design/glb_read_arbiter.sv ====
`timescale 1ns/1ps

module glb_read_arbiter (
    input  ipsum_ctrl_pkg::glb_rd_req_t    ipsum_req_i,
    input  ipsum_ctrl_pkg::glb_rd_req_t    other_req_i,
    output ipsum_ctrl_pkg::glb_rd_grant_t  grant_o,
    output logic                           other_gnt_o
);

    // The weight-side port always wins
    assign other_gnt_o = other_req_i.req;

    // Ipsum path only gets the port when the other side is quiet
    assign grant_o.permit_ipsum = ipsum_req_i.req && !other_req_i.req;

    // Address mux for the single read port
    always_comb begin
        if (other_req_i.req) begin
            grant_o.addr = other_req_i.addr;
        end else begin
            grant_o.addr = ipsum_req_i.addr;
        end
    end

endmodule

// ==== design/glb_bank.sv ====
`timescale 1ns/1ps

module glb_bank #(
    parameter int unsigned GLB_DEPTH = ipsum_cfg_pkg::GLB_DEPTH_DEF
) (
    input  logic                        clk,
    input  logic                        wr_en_i,
    input  ipsum_cfg_pkg::glb_addr_t    wr_addr_i,
    input  ipsum_cfg_pkg::ipsum_word_t  wr_data_i,
    input  ipsum_cfg_pkg::glb_addr_t    rd_addr_i,
    output ipsum_cfg_pkg::ipsum_word_t  rd_data_o
);

    import ipsum_cfg_pkg::*;

    localparam int unsigned AW = (GLB_DEPTH > 1) ? $clog2(GLB_DEPTH) : 1;

    ipsum_word_t   mem [GLB_DEPTH];
    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd_idx;

    // Addresses wrap around the bank
    assign wr_idx = AW'(wr_addr_i % GLB_DEPTH);
    assign rd_idx = AW'(rd_addr_i % GLB_DEPTH);

    // Loaded from the top-level write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx] <= wr_data_i;
        end
    end

    // Combinational read, same-cycle data for the FIFO push
    assign rd_data_o = mem[rd_idx];

endmodule

// ==== design/ipsum_top.sv ====
`timescale 1ns/1ps

module ipsum_top #(
    parameter int unsigned FIFO_DEPTH = ipsum_cfg_pkg::FIFO_DEPTH_DEF,
    parameter int unsigned GLB_DEPTH  = ipsum_cfg_pkg::GLB_DEPTH_DEF
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // Task control
    input  logic                         need_pop_i,
    input  ipsum_cfg_pkg::pop_num_t      pop_num_i,
    input  logic                         fifo_reset_i,
    input  ipsum_cfg_pkg::glb_addr_t     base_addr_i,

    // Competing GLB reader
    input  ipsum_ctrl_pkg::glb_rd_req_t  other_req_i,
    output logic                         other_gnt_o,
    output ipsum_cfg_pkg::ipsum_word_t   other_rd_data_o,

    // GLB load port
    input  logic                         glb_wr_en_i,
    input  ipsum_cfg_pkg::glb_addr_t     glb_wr_addr_i,
    input  ipsum_cfg_pkg::ipsum_word_t   glb_wr_data_i,

    // Toward the array
    output logic                         ipsum_valid_o,
    output ipsum_cfg_pkg::ipsum_word_t   ipsum_data_o,
    output logic                         done_o
);

    import ipsum_cfg_pkg::*;
    import ipsum_ctrl_pkg::*;

    glb_rd_req_t   ipsum_req;
    glb_rd_grant_t grant;
    fifo_status_t  fifo_status;
    logic          fifo_push;
    logic          fifo_pop;
    ipsum_word_t   fifo_head;
    ipsum_word_t   glb_rd_data;

    ipsum_fifo_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .need_pop_i    (need_pop_i),
        .pop_num_i     (pop_num_i),
        .fifo_reset_i  (fifo_reset_i),
        .base_addr_i   (base_addr_i),
        .fifo_status_i (fifo_status),
        .permit_push_i (grant.permit_ipsum),
        .rd_req_o      (ipsum_req),
        .push_o        (fifo_push),
        .pop_o         (fifo_pop),
        .done_o        (done_o)
    );

    ipsum_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (fifo_reset_i),
        .push_i      (fifo_push),
        .push_data_i (glb_rd_data),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .status_o    (fifo_status)
    );

    glb_read_arbiter u_arb (
        .ipsum_req_i (ipsum_req),
        .other_req_i (other_req_i),
        .grant_o     (grant),
        .other_gnt_o (other_gnt_o)
    );

    glb_bank #(
        .GLB_DEPTH (GLB_DEPTH)
    ) u_glb (
        .clk       (clk),
        .wr_en_i   (glb_wr_en_i),
        .wr_addr_i (glb_wr_addr_i),
        .wr_data_i (glb_wr_data_i),
        .rd_addr_i (grant.addr),
        .rd_data_o (glb_rd_data)
    );

    // Read data is shared, valid for whoever holds the grant
    assign other_rd_data_o = glb_rd_data;

    // Popped head goes straight out with the pop strobe
    assign ipsum_valid_o = fifo_pop;
    assign ipsum_data_o  = fifo_head;

endmodule

// ==== testbench/ipsum_props.sv ====
`timescale 1ns/1ps

module ipsum_props #(
    parameter int unsigned DEPTH = ipsum_cfg_pkg::FIFO_DEPTH_DEF
) (
    input logic                          clk,
    input logic                          rst_n,
    input ipsum_ctrl_pkg::ctrl_state_t   state,
    input logic                          need_pop,
    input ipsum_cfg_pkg::pop_num_t       pop_num,
    input logic                          clear,
    input ipsum_ctrl_pkg::fifo_status_t  status,
    input logic                          push,
    input logic                          pop,
    input logic                          done
);

    import ipsum_ctrl_pkg::*;

    localparam logic [15:0] DEPTH_C = 16'(DEPTH);

    logic [15:0] occ_q;

    // FIFO occupancy rebuilt from the strobes alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ_q <= '0;
        end else if (clear) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_q + 16'(push) - 16'(pop);
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (occ_q < DEPTH_C))
        else $error("push strobe while FIFO full");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (occ_q != '0))
        else $error("pop strobe while FIFO empty");

    // Flags follow the rebuilt occupancy
    flags_match: assert property (@(posedge clk) disable iff (!rst_n)
        (status.full == (occ_q == DEPTH_C)) && (status.empty == (occ_q == '0)))
        else $error("FIFO flags disagree with its occupancy");

    // Zero-length task is illegal
    nonzero_pop_num: assert property (@(posedge clk) disable iff (!rst_n)
        (need_pop && done) |-> (pop_num != '0))
        else $error("task started with a pop count of zero");

    done_drops: assert property (@(posedge clk) disable iff (!rst_n)
        (need_pop && done) |=> !done)
        else $error("done stayed high after a task start");

    // A refill ends with a full FIFO
    refill_fills: assert property (@(posedge clk) disable iff (!rst_n)
        (state == POP && $past(state) == PUSH) |-> (occ_q == DEPTH_C))
        else $error("refill ended before the FIFO was full");

endmodule

bind ipsum_fifo_ctrl ipsum_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state_q),
    .need_pop (need_pop_i),
    .pop_num  (pop_num_i),
    .clear    (fifo_reset_i),
    .status   (fifo_status_i),
    .push     (push_o),
    .pop      (pop_o),
    .done     (done_o)
);

// ==== testbench/tb_ipsum_top.sv ====
`timescale 1ns/1ps

module tb_ipsum_top;

    import ipsum_cfg_pkg::*;
    import ipsum_ctrl_pkg::*;

    localparam int unsigned FIFO_DEPTH = 8;
    localparam int unsigned GLB_DEPTH  = 256;
    localparam int unsigned TIMEOUT    = 5000;

    logic        clk;
    logic        rst_n;
    logic        need_pop_i;
    pop_num_t    pop_num_i;
    logic        fifo_reset_i;
    glb_addr_t   base_addr_i;
    glb_rd_req_t other_req_i;
    logic        other_gnt_o;
    ipsum_word_t other_rd_data_o;
    logic        glb_wr_en_i;
    glb_addr_t   glb_wr_addr_i;
    ipsum_word_t glb_wr_data_i;
    logic        ipsum_valid_o;
    ipsum_word_t ipsum_data_o;
    logic        done_o;

    logic [31:0] td [0:127];
    logic [31:0] fill_mul;
    logic [31:0] fill_xor;
    integer      seed;
    string       cur_test;
    int unsigned base_cur;
    int unsigned k;
    int unsigned popped;
    logic        running;
    ipsum_word_t exp_pop;
    ipsum_word_t exp_other;

    ipsum_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .GLB_DEPTH  (GLB_DEPTH)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .need_pop_i      (need_pop_i),
        .pop_num_i       (pop_num_i),
        .fifo_reset_i    (fifo_reset_i),
        .base_addr_i     (base_addr_i),
        .other_req_i     (other_req_i),
        .other_gnt_o     (other_gnt_o),
        .other_rd_data_o (other_rd_data_o),
        .glb_wr_en_i     (glb_wr_en_i),
        .glb_wr_addr_i   (glb_wr_addr_i),
        .glb_wr_data_i   (glb_wr_data_i),
        .ipsum_valid_o   (ipsum_valid_o),
        .ipsum_data_o    (ipsum_data_o),
        .done_o          (done_o)
    );

    always #4 clk = ~clk;

    // GLB content rule, every address gets its own word
    function automatic ipsum_word_t glb_word(input int unsigned addr);
        return (addr * fill_mul) ^ fill_xor;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        report_failure($sformatf("Mismatch in %s (%s): expected %h, actual %h",
                                 cur_test, what, exp, act));
    endtask

    task automatic drive_other(input int unsigned prob);
        int unsigned roll;
        roll = $unsigned($random(seed)) % 100;
        other_req_i.req  <= (roll < prob);
        other_req_i.addr <= glb_addr_t'($unsigned($random(seed)));
    endtask

    // Both output streams are checked mid-cycle, away from the drive edge
    always @(negedge clk) begin
        if (rst_n && running) begin
            if (ipsum_valid_o) begin
                exp_pop = glb_word((base_cur + k) % GLB_DEPTH);
                assert (ipsum_data_o == exp_pop)
                    else report_mismatch("pop data", exp_pop, ipsum_data_o);
                k++;
                popped++;
            end
            // Other reader has fixed priority
            assert (other_gnt_o == other_req_i.req)
                else report_mismatch("other grant", other_req_i.req, other_gnt_o);
            if (other_req_i.req) begin
                exp_other = glb_word(int'(other_req_i.addr) % GLB_DEPTH);
                assert (other_rd_data_o == exp_other)
                    else report_mismatch("other read", exp_other, other_rd_data_o);
            end
        end
    end

    task automatic run_pop(input int unsigned n, input int unsigned prob,
                           input int unsigned exp_k);
        int unsigned cycles;
        cycles = 0;
        popped = 0;
        @(posedge clk);
        need_pop_i <= 1'b1;
        pop_num_i  <= pop_num_t'(n);
        @(posedge clk);
        need_pop_i <= 1'b0;
        drive_other(prob);
        @(negedge clk);
        while (!done_o) begin
            assert (cycles < TIMEOUT)
                else report_failure($sformatf("%s: done never returned high", cur_test));
            @(posedge clk);
            drive_other(prob);
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        other_req_i <= '0;
        @(negedge clk);
        assert (popped == n) else report_mismatch("word count", n, popped);
        assert (k == exp_k) else report_mismatch("sequence position", exp_k, k);
    endtask

    task automatic restart_fifo(input int unsigned new_base);
        @(posedge clk);
        fifo_reset_i <= 1'b1;
        base_addr_i  <= glb_addr_t'(new_base);
        @(posedge clk);
        fifo_reset_i <= 1'b0;
        k        = 0;
        base_cur = new_base;
    endtask

    initial begin
        int unsigned p;
        int unsigned n_task;
        clk           = 1'b0;
        rst_n         = 1'b0;
        need_pop_i    = 1'b0;
        pop_num_i     = '0;
        fifo_reset_i  = 1'b0;
        base_addr_i   = '0;
        other_req_i   = '0;
        glb_wr_en_i   = 1'b0;
        glb_wr_addr_i = '0;
        glb_wr_data_i = '0;
        seed          = 45096;
        base_cur      = 0;
        k             = 0;
        popped        = 0;
        running       = 1'b0;
        cur_test      = "reset";
        n_task        = 0;
        for (int i = 0; i < 128; i++) begin
            td[i] = '0;
        end
        $readmemh("testbench/ipsum_testdata.txt", td);
        fill_mul = td[0];
        fill_xor = td[1];

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        assert (done_o && !ipsum_valid_o && !other_gnt_o)
            else report_failure("outputs not at their idle values after reset");

        // Load the whole GLB through the write port
        for (int a = 0; a < GLB_DEPTH; a++) begin
            @(posedge clk);
            glb_wr_en_i   <= 1'b1;
            glb_wr_addr_i <= glb_addr_t'(a);
            glb_wr_data_i <= glb_word(a);
        end
        @(posedge clk);
        glb_wr_en_i <= 1'b0;
        running = 1'b1;

        p = 4;
        while (td[p] != 0 && p < 124) begin
            if (td[p] == 1) begin
                n_task++;
                cur_test = $sformatf("task %0d pop %0d", n_task, td[p+1]);
                run_pop(td[p+1], td[p+2], td[p+3]);
            end else if (td[p] == 2) begin
                cur_test = $sformatf("fifo reset base %0h", td[p+1]);
                restart_fifo(td[p+1]);
            end else begin
                report_failure($sformatf("unknown record type %0d in test data", td[p]));
            end
            p += 4;
        end

        if (n_task > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_failure("test data holds no pop task");
        end
    end

endmodule

// ==== testbench/ipsum_testdata.txt ====
// Row 0: GLB fill multiplier, GLB fill xor mask, unused, unused
// Rows after: op, arg_a, arg_b, arg_c
// op 1 pop task: pop count, other-port request percent, expected words popped since FIFO reset
// op 2 FIFO reset: new base address, unused, unused
// op 0 ends the list
9E3779B1 5A5A0000 00000000 00000000
// Empty FIFO, short task, leaves words behind
00000001 00000005 00000000 00000005
// Leftover words first, then refills
00000001 00000014 00000000 00000019
// Back-pressure from the other reader
00000001 0000001E 00000028 00000037
00000001 00000002 00000000 00000039
// Heavy back-pressure, odd count
00000001 0000000B 00000050 00000044
// Restart near the top of the GLB, wraps past address 255
00000002 000000F0 00000000 00000000
00000001 0000000C 00000019 0000000C
00000001 00000028 0000001E 00000034
// Restart at a new base
00000002 00000020 00000000 00000000
00000001 00000003 00000000 00000003
00000001 00000009 0000003C 0000000C
00000001 00000001 00000000 0000000D
// Reset twice in a row before the next task
00000002 00000077 00000000 00000000
00000002 00000010 00000000 00000000
00000001 00000011 00000032 00000011
00000000 00000000 00000000 00000000

// ==== all.f ====
design/ipsum_cfg_pkg.sv
design/ipsum_ctrl_pkg.sv
design/ipsum_fifo_ctrl.sv
design/ipsum_fifo.sv
design/glb_read_arbiter.sv
design/glb_bank.sv
design/ipsum_top.sv
testbench/ipsum_props.sv
testbench/tb_ipsum_top.sv

// ==== Makefile ====
TOP = tb_ipsum_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir
